// File: logic/calcControl.sv
`default_nettype none

module calcControl
	import calcPkg::*;
(
	input  logic    CLK_in,
	input  logic    arstN,
	input  logic    cmdReq,
	input  cmdT     cmd,
	output logic    cmdAck,
	calcCtrlIf.ctrl ctl
);

	ctrlStateT state, nextState;
	opT        pendOp;   // Kept until clear

	// ------------------------------------------------------------
	// Next state and strobes
	// ------------------------------------------------------------

	always_comb begin
		nextState     = state;
		ctl.clrAcc    = 1'b0;
		ctl.ldNum     = 1'b0;
		ctl.accLoad   = 1'b0;
		ctl.addSubGo  = 1'b0;
		ctl.subSel    = 1'b0;
		ctl.mulStart  = 1'b0;
		ctl.mulStep   = 1'b0;
		ctl.mulFinish = 1'b0;
		ctl.divStart  = 1'b0;
		ctl.divStep   = 1'b0;
		ctl.divFinish = 1'b0;
		case (state)
			StIdle: begin
				if (cmdReq && !cmdAck) nextState = StExec;   // New request only after ack low
			end
			StExec: begin
				case (cmd)
					CmdClear: begin
						ctl.clrAcc = 1'b1;
						nextState  = StAck;
					end
					CmdEquals: begin
						ctl.ldNum = 1'b1;   // Number register valid next cycle
						nextState = StEqual;
					end
					default: nextState = StAck;   // Operator only recorded
				endcase
			end
			StEqual: begin
				case (pendOp)
					OpAdd, OpSub: begin
						ctl.addSubGo = 1'b1;
						ctl.subSel   = (pendOp == OpSub);
						nextState    = StAck;
					end
					OpMul: begin
						ctl.mulStart = 1'b1;
						nextState    = StMulCheck;
					end
					OpDiv: begin
						ctl.divStart = 1'b1;
						nextState    = StDivSetup;
					end
					default: begin
						ctl.accLoad = 1'b1;   // Nothing pending
						nextState   = StAck;
					end
				endcase
			end
			StMulCheck: begin
				if (ctl.mulLast) begin
					ctl.mulFinish = 1'b1;
					nextState     = StAck;
				end else if (ctl.mulBits == 2'b01) begin
					nextState = StMulAdd;
				end else if (ctl.mulBits == 2'b10) begin
					nextState = StMulSub;
				end else begin
					nextState = StMulShift;   // 00 or 11, shift only
				end
			end
			StMulAdd, StMulSub: begin
				ctl.addSubGo = 1'b1;   // Add or subtract plus shift in one step
				ctl.subSel   = (state == StMulSub);
				nextState    = StMulCheck;
			end
			StMulShift: begin
				ctl.mulStep = 1'b1;
				nextState   = StMulCheck;
			end
			StDivSetup: begin
				// Zero divisor skips the loop, acc untouched
				nextState = ctl.divZero ? StAck : StDivLoop;
			end
			StDivLoop: begin
				if (ctl.divMore) ctl.divStep = 1'b1;
				else             nextState   = StDivFinish;
			end
			StDivFinish: begin
				ctl.divFinish = 1'b1;
				nextState     = StAck;
			end
			StAck: begin
				if (!cmdReq) nextState = StIdle;   // Strobes stay low meanwhile
			end
			default: nextState = StIdle;
		endcase
	end

	// ------------------------------------------------------------
	// State, pending op and ack registers
	// ------------------------------------------------------------

	always_ff @(posedge CLK_in or negedge arstN) begin
		if (!arstN) begin
			state  <= StIdle;
			pendOp <= OpNone;
			cmdAck <= 1'b0;
		end else begin
			state  <= nextState;
			cmdAck <= (nextState == StAck);   // Falls with the return to idle
			if (state == StExec) begin
				case (cmd)
					CmdClear: pendOp <= OpNone;
					CmdAdd:   pendOp <= OpAdd;
					CmdSub:   pendOp <= OpSub;
					CmdMul:   pendOp <= OpMul;
					CmdDiv:   pendOp <= OpDiv;
					default:  pendOp <= pendOp;   // Equals keeps it
				endcase
			end
		end
	end

	// Ack only rises after a command has run, never straight out of idle
	aAckAfterWork: assert property (@(posedge CLK_in) disable iff (!arstN)
		$rose(cmdAck) |-> $past(state) != StIdle);

	// One accumulator source per cycle
	aOneStart: assert property (@(posedge CLK_in) disable iff (!arstN)
		$onehot0({ctl.accLoad, ctl.addSubGo, ctl.mulStart, ctl.divStart}));

endmodule

`default_nettype wire

// File: logic/calcCtrlIf.sv
`default_nettype none

interface calcCtrlIf;

	// Strobes from the controller, one cycle each
	logic clrAcc;     // Acc and overflow to zero
	logic ldNum;      // Capture converted number
	logic accLoad;    // Acc takes the number
	logic addSubGo;   // Shared adder result written back
	logic subSel;     // Adder subtracts
	logic mulStart;
	logic mulStep;    // Booth shift only
	logic mulFinish;
	logic divStart;
	logic divStep;
	logic divFinish;

	// Status from the datapath
	logic [1:0] mulBits;   // Booth examine pair
	logic       mulLast;   // Iterations used up
	logic       divZero;
	logic       divMore;   // Remainder still >= divisor

	modport ctrl (
		output clrAcc, ldNum, accLoad, addSubGo, subSel,
		output mulStart, mulStep, mulFinish, divStart, divStep, divFinish,
		input  mulBits, mulLast, divZero, divMore
	);

	modport dp (
		input  clrAcc, ldNum, accLoad, addSubGo, subSel,
		input  mulStart, mulStep, mulFinish, divStart, divStep, divFinish,
		output mulBits, mulLast, divZero, divMore
	);

endinterface

`default_nettype wire

// File: logic/calcDatapath.sv
`default_nettype none

module calcDatapath #(
	parameter int W = 11
) (
	input  logic         CLK_in,
	input  logic         arstN,
	input  logic [W-1:0] number,     // Signed magnitude
	output logic [W-1:0] result,     // Two's complement
	output logic         overflow,
	calcCtrlIf.dp        dp
);

	typedef logic signed [W-1:0]    numT;
	typedef logic [W-1:0]           magT;
	typedef logic [2*W:0]           prodT;   // Upper, multiplier, Booth bit
	typedef logic [$clog2(W+1)-1:0] cntT;

	numT  numTc, numReg, acc;
	magT  smMag;
	logic mulPhase;   // Adder works on the product
	prodT prod;
	cntT  mulCnt;
	magT  dvdMag, dvsMag, quot;
	logic divNeg;     // Quotient sign

	// ------------------------------------------------------------
	// Number conversion
	// ------------------------------------------------------------

	assign smMag = {1'b0, number[W-2:0]};
	assign numTc = number[W-1] ? numT'(-smMag) : numT'(smMag);   // -0 comes out as 0

	// Shared adder, one extra bit for the true sign
	numT                addA, addB;
	logic signed [W:0]  sumExt;
	logic               addOvf;
	logic [W:0]         prodHigh;
	logic               prodOvf;

	assign addA     = mulPhase ? numT'(prod[2*W:W+1]) : acc;
	assign addB     = mulPhase ? acc : numReg;   // Acc is the multiplicand
	assign sumExt   = dp.subSel ? addA - addB : addA + addB;
	assign addOvf   = sumExt[W] ^ sumExt[W-1];
	assign prodHigh = prod[2*W:W];
	assign prodOvf  = (|prodHigh) && !(&prodHigh);   // Upper bits not pure sign

	// ------------------------------------------------------------
	// Accumulator and overflow flag
	// ------------------------------------------------------------

	always_ff @(posedge CLK_in or negedge arstN) begin
		if (!arstN) begin
			acc      <= '0;
			overflow <= 1'b0;
			mulPhase <= 1'b0;
		end else begin
			if (dp.clrAcc) begin
				acc      <= '0;
				overflow <= 1'b0;
				mulPhase <= 1'b0;
			end
			if (dp.ldNum) overflow <= 1'b0;   // Every equals starts clean
			if (dp.accLoad) acc <= numReg;
			if (dp.addSubGo && !mulPhase) begin
				acc      <= numT'(sumExt);
				overflow <= addOvf;
			end
			if (dp.mulStart) mulPhase <= 1'b1;
			if (dp.mulFinish) begin
				acc      <= numT'(prod[W:1]);
				overflow <= prodOvf;
				mulPhase <= 1'b0;
			end
			if (dp.divStart) overflow <= (numReg == '0);   // Divide by zero
			if (dp.divFinish) acc <= divNeg ? numT'(-quot) : numT'(quot);
		end
	end

	// ------------------------------------------------------------
	// Number register, Booth product, divider
	// ------------------------------------------------------------

	always_ff @(posedge CLK_in) begin
		if (dp.ldNum) numReg <= numTc;
		if (dp.mulStart) begin
			prod   <= {{W{1'b0}}, numReg, 1'b0};
			mulCnt <= cntT'(W);
		end else if (dp.addSubGo && mulPhase) begin
			prod   <= {sumExt, prod[W:1]};   // Add and arithmetic shift together
			mulCnt <= mulCnt - 1'b1;
		end else if (dp.mulStep) begin
			prod   <= {prod[2*W], prod[2*W:1]};
			mulCnt <= mulCnt - 1'b1;
		end
		if (dp.divStart) begin
			dvdMag <= acc[W-1] ? magT'(-acc) : magT'(acc);
			dvsMag <= numReg[W-1] ? magT'(-numReg) : magT'(numReg);
			quot   <= '0;
			divNeg <= acc[W-1] ^ numReg[W-1];
		end else if (dp.divStep) begin
			dvdMag <= dvdMag - dvsMag;
			quot   <= quot + 1'b1;
		end
	end

	// Status back to the controller
	assign dp.mulBits = prod[1:0];
	assign dp.mulLast = (mulCnt == '0);
	assign dp.divZero = (dvsMag == '0);
	assign dp.divMore = (dvdMag >= dvsMag);

	assign result = acc;

	// Controller must have left the loop on a zero divisor
	aNoZeroStep: assert property (@(posedge CLK_in) disable iff (!arstN)
		dp.divStep |-> !dp.divZero);

endmodule

`default_nettype wire

// File: logic/calcPkg.sv
`default_nettype none

package calcPkg;

	// ------------------------------------------------------------
	// Command and operation codes
	// ------------------------------------------------------------

	typedef enum logic [2:0] {
		CmdClear,
		CmdEquals,
		CmdAdd,
		CmdSub,
		CmdMul,
		CmdDiv
	} cmdT;

	// Operation waiting for the next equals
	typedef enum logic [2:0] {
		OpNone,
		OpAdd,
		OpSub,
		OpMul,
		OpDiv
	} opT;

	typedef enum logic [3:0] {
		StIdle,       // Waiting for a request
		StExec,       // Command decode
		StEqual,      // Equals dispatch on pending op
		StMulCheck,   // Booth examine bits
		StMulAdd,
		StMulSub,
		StMulShift,
		StDivSetup,   // Divisor zero test
		StDivLoop,    // Repeated subtraction
		StDivFinish,
		StAck         // Hold ack until req drops
	} ctrlStateT;

	// ------------------------------------------------------------
	// Seven-segment encoding, active low, bit 0 is segment a
	// ------------------------------------------------------------

	typedef logic [6:0] segT;

	localparam segT segDigits [10] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
		7'h12, 7'h02, 7'h78, 7'h00, 7'h10
	};

	localparam segT segMinus = 7'h3F;   // Only segment g lit
	localparam segT segOff   = 7'h7F;   // Blank digit

	localparam int unsigned dispMax = 999;   // Three decimal digits

endpackage

`default_nettype wire

// File: logic/segDisplay.sv
`default_nettype none

module segDisplay
	import calcPkg::*;
#(
	parameter int W = 11
) (
	input  logic [W-1:0] value,   // Two's complement
	output segT          sign,
	output segT          d2,
	output segT          d1,
	output segT          d0
);

	logic [W-1:0] mag;
	logic [3:0]   dig2, dig1, dig0;
	logic         tooLarge;

	// Magnitude, most negative value still fits unsigned
	assign mag      = value[W-1] ? -value : value;
	assign tooLarge = (mag > dispMax);

	// Decimal split
	assign dig0 = 4'(mag % 10);
	assign dig1 = 4'((mag / 10) % 10);
	assign dig2 = 4'((mag / 100) % 10);

	// ------------------------------------------------------------
	// Segment selection, dashes when out of range
	// ------------------------------------------------------------

	always_comb begin
		if (tooLarge) begin
			sign = segMinus;
			d2   = segMinus;
			d1   = segMinus;
			d0   = segMinus;
		end else begin
			sign = value[W-1] ? segMinus : segOff;
			d2   = (dig2 == 4'd0) ? segOff : segDigits[dig2];   // Leading zero blank
			d1   = (dig2 == 4'd0 && dig1 == 4'd0) ? segOff : segDigits[dig1];
			d0   = segDigits[dig0];   // Always shown
		end
	end

endmodule

`default_nettype wire

// File: logic/seqCalc.sv
`default_nettype none

module seqCalc
	import calcPkg::*;
#(
	parameter int W = 11
) (
	input  logic         CLK_in,
	input  logic         arstN,
	input  logic         cmdReq,
	output logic         cmdAck,
	input  cmdT          cmd,
	input  logic [W-1:0] number,     // Signed magnitude
	output logic [W-1:0] result,     // Two's complement
	output logic         overflow,
	output segT          hex3,       // Sign digit
	output segT          hex2,
	output segT          hex1,
	output segT          hex0
);

	// Controller to datapath strobes and status
	calcCtrlIf ctlIf ();

	calcControl uControl (
		.CLK_in (CLK_in),
		.arstN  (arstN),
		.cmdReq (cmdReq),
		.cmd    (cmd),
		.cmdAck (cmdAck),
		.ctl    (ctlIf.ctrl)
	);

	calcDatapath #(
		.W (W)
	) uDatapath (
		.CLK_in   (CLK_in),
		.arstN    (arstN),
		.number   (number),
		.result   (result),
		.overflow (overflow),
		.dp       (ctlIf.dp)
	);

	// Display follows the accumulator directly
	segDisplay #(
		.W (W)
	) uDisplay (
		.value (result),
		.sign  (hex3),
		.d2    (hex2),
		.d1    (hex1),
		.d0    (hex0)
	);

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Build and run the seqCalc testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module calcTb \
	-f seqCalc.f -o calcSim > build.log 2>&1 \
	&& ./obj_dir/calcSim > sim.log 2>&1 \
	&& grep -qx "test passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see build.log and sim.log"; exit 1; }

// File: seqCalc.f
logic/calcPkg.sv
logic/calcCtrlIf.sv
logic/calcControl.sv
logic/calcDatapath.sv
logic/segDisplay.sv
logic/seqCalc.sv
sim/calcTb.sv

// File: sim/calcTb.sv
`default_nettype none

module calcTb
	import calcPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int W         = 11;
	localparam int maxVal    = 2 ** (W - 1) - 1;
	localparam int minVal    = -(2 ** (W - 1));
	localparam int ackLimit  = 4000;   // Longest divide loop plus margin
	localparam int dropLimit = 8;

	logic         CLK_in = 1'b0;
	logic         arstN;
	logic         cmdReq;
	logic         cmdAck;
	cmdT          cmd;
	logic [W-1:0] number;          // Signed magnitude
	logic [W-1:0] result;
	logic         overflow;
	segT          hex3, hex2, hex1, hex0;

	// Reference model
	int           modelAcc;
	opT           modelOp;
	logic         modelOvf;
	logic [W-1:0] expResult;
	segT          expHex3, expHex2, expHex1, expHex0;
	int           errCount;
	int           timeoutCount;

	seqCalc #(
		.W (W)
	) u_dut (
		.CLK_in   (CLK_in),
		.arstN    (arstN),
		.cmdReq   (cmdReq),
		.cmdAck   (cmdAck),
		.cmd      (cmd),
		.number   (number),
		.result   (result),
		.overflow (overflow),
		.hex3     (hex3),
		.hex2     (hex2),
		.hex1     (hex1),
		.hex0     (hex0)
	);

	always #2 CLK_in = ~CLK_in;   // 4 ns period

	// ------------------------------------------------------------
	// Output checks while the ack is up
	// ------------------------------------------------------------

	aResult: assert property (@(posedge CLK_in) disable iff (!arstN)
		cmdAck |-> result == expResult) else begin
		errCount++;
		$display("Mismatch result: expected %h, actual %h", expResult, result);
	end
	aOverflow: assert property (@(posedge CLK_in) disable iff (!arstN)
		cmdAck |-> overflow == modelOvf) else begin
		errCount++;
		$display("Mismatch overflow: expected %h, actual %h", modelOvf, overflow);
	end
	aHex3: assert property (@(posedge CLK_in) disable iff (!arstN)
		cmdAck |-> hex3 == expHex3) else begin
		errCount++;
		$display("Mismatch hex3: expected %h, actual %h", expHex3, hex3);
	end
	aHex2: assert property (@(posedge CLK_in) disable iff (!arstN)
		cmdAck |-> hex2 == expHex2) else begin
		errCount++;
		$display("Mismatch hex2: expected %h, actual %h", expHex2, hex2);
	end
	aHex1: assert property (@(posedge CLK_in) disable iff (!arstN)
		cmdAck |-> hex1 == expHex1) else begin
		errCount++;
		$display("Mismatch hex1: expected %h, actual %h", expHex1, hex1);
	end
	aHex0: assert property (@(posedge CLK_in) disable iff (!arstN)
		cmdAck |-> hex0 == expHex0) else begin
		errCount++;
		$display("Mismatch hex0: expected %h, actual %h", expHex0, hex0);
	end

	// Signed value to sign bit plus magnitude
	function automatic logic [W-1:0] toSm(input int v);
		logic [W-1:0] code;
		code[W-1]   = (v < 0);
		code[W-2:0] = (W-1)'((v < 0) ? -v : v);
		return code;
	endfunction

	function automatic logic [W-1:0] randSm(input int maxMag);
		logic [W-1:0] code;
		code[W-2:0] = (W-1)'($urandom_range(maxMag, 0));
		code[W-1]   = 1'($urandom_range(1, 0));   // -0 shows up now and then
		return code;
	endfunction

	function automatic int smValue(input logic [W-1:0] num);
		int mag;
		mag = int'(num[W-2:0]);
		return num[W-1] ? -mag : mag;
	endfunction

	// Keep the low W bits, sign extended
	function automatic int wrapW(input int v);
		logic signed [W-1:0] low;
		low = v[W-1:0];
		return int'(low);
	endfunction

	task automatic setDisplay(input int v);
		int mag;
		mag = (v < 0) ? -v : v;
		if (mag > dispMax) begin
			{expHex3, expHex2, expHex1, expHex0} = {4{segMinus}};   // All dashes
		end else begin
			expHex3 = (v < 0) ? segMinus : segOff;
			expHex2 = (mag >= 100) ? segDigits[mag / 100] : segOff;
			expHex1 = (mag >= 10) ? segDigits[(mag / 10) % 10] : segOff;
			expHex0 = segDigits[mag % 10];
		end
	endtask

	task automatic applyModel(input cmdT c, input logic [W-1:0] num);
		int n;
		int full;
		int aMag;
		int nMag;
		n = smValue(num);
		case (c)
			CmdClear: begin
				modelAcc = 0;
				modelOvf = 1'b0;
				modelOp  = OpNone;
			end
			CmdAdd: modelOp = OpAdd;
			CmdSub: modelOp = OpSub;
			CmdMul: modelOp = OpMul;
			CmdDiv: modelOp = OpDiv;
			default: begin   // Equals
				case (modelOp)
					OpNone:  full = n;
					OpAdd:   full = modelAcc + n;
					OpSub:   full = modelAcc - n;
					OpMul:   full = modelAcc * n;
					default: full = modelAcc;
				endcase
				modelOvf = (full > maxVal || full < minVal);
				if (modelOp == OpDiv) begin
					aMag = (modelAcc < 0) ? -modelAcc : modelAcc;
					nMag = (n < 0) ? -n : n;
					modelOvf = (n == 0);   // Zero divisor keeps acc
					if (n != 0) full = ((modelAcc < 0) != (n < 0)) ? -(aMag / nMag) : aMag / nMag;
				end
				modelAcc = wrapW(full);
			end
		endcase
		expResult = W'(modelAcc);
		setDisplay(modelAcc);
	endtask

	// ------------------------------------------------------------
	// Four-phase command, called on a falling edge
	// ------------------------------------------------------------

	task automatic issueCmd(input cmdT c, input logic [W-1:0] num);
		int waitCnt;
		applyModel(c, num);
		cmd     = c;
		number  = num;
		cmdReq  = 1'b1;
		waitCnt = 0;
		while (!cmdAck && waitCnt < ackLimit) begin
			@(negedge CLK_in);
			waitCnt++;
		end
		if (!cmdAck) begin
			timeoutCount++;
			$display("Timeout: cmdAck never rose for command %s", c.name());
		end
		cmdReq  = 1'b0;
		waitCnt = 0;
		while (cmdAck && waitCnt < dropLimit) begin
			@(negedge CLK_in);
			waitCnt++;
		end
		if (cmdAck) begin
			timeoutCount++;
			$display("Timeout: cmdAck stayed high after cmdReq fell");
		end
	endtask

	initial begin
		void'($urandom(46044));
		cmdReq       = 1'b0;
		cmd          = CmdClear;
		number       = '0;
		arstN        = 1'b0;
		errCount     = 0;
		timeoutCount = 0;
		applyModel(CmdClear, '0);
		repeat (16) @(negedge CLK_in);
		arstN = 1'b1;
		@(negedge CLK_in);
		aReset: assert (!cmdAck && result == '0 && !overflow) else begin
			errCount++;
			$display("Mismatch after reset: expected cmdAck/result/overflow 0/000/0, actual %h/%h/%h",
				cmdAck, result, overflow);
		end

		// Plain loads
		issueCmd(CmdEquals, toSm(123));
		issueCmd(CmdEquals, toSm(-456));
		issueCmd(CmdEquals, 11'h400);      // Negative zero
		issueCmd(CmdEquals, toSm(1000));   // Dashes
		issueCmd(CmdEquals, toSm(45));
		issueCmd(CmdEquals, toSm(7));

		// Add and subtract across the range edges
		issueCmd(CmdAdd, '0);
		issueCmd(CmdEquals, toSm(1016));   // 1023
		issueCmd(CmdEquals, toSm(1));      // Wraps to -1024
		issueCmd(CmdEquals, toSm(1));
		issueCmd(CmdSub, '0);
		issueCmd(CmdEquals, toSm(5));
		issueCmd(CmdEquals, toSm(-20));
		issueCmd(CmdEquals, toSm(8));
		repeat (20) begin
			if ($urandom_range(1, 0) != 0) issueCmd(CmdAdd, '0);
			else issueCmd(CmdSub, '0);
			issueCmd(CmdEquals, randSm(1023));
		end

		// Multiply, with a repeat of the pending op
		repeat (25) begin
			issueCmd(CmdClear, '0);
			issueCmd(CmdEquals, randSm(1023 >> $urandom_range(6, 0)));
			issueCmd(CmdMul, '0);
			issueCmd(CmdEquals, randSm(1023 >> $urandom_range(6, 0)));
			issueCmd(CmdEquals, randSm(3));
		end

		// Divide, small divisors give long loops
		repeat (20) begin
			issueCmd(CmdClear, '0);
			issueCmd(CmdEquals, randSm(1023));
			issueCmd(CmdDiv, '0);
			issueCmd(CmdEquals, randSm(1023 >> $urandom_range(9, 0)));
		end
		issueCmd(CmdEquals, toSm(0));
		issueCmd(CmdEquals, 11'h400);
		issueCmd(CmdEquals, toSm(-3));

		// Clear forgets the pending op
		issueCmd(CmdMul, '0);
		issueCmd(CmdClear, '0);
		issueCmd(CmdEquals, toSm(42));
		issueCmd(CmdEquals, toSm(-9));

		$display("Closing count: %0d mismatches, %0d timeouts", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
